// File: source/ogfx_reg_pkg.sv
package ogfx_reg_pkg;

  //--------------------------------------------------------------------
  // Peripheral bus
  //--------------------------------------------------------------------
  typedef struct packed {
    logic [7:0]  addr;                       // Word address
    logic [15:0] din;
    logic        en;
    logic        we;
  } per_bus_t;

  localparam logic [7:0] REG_CTRL = 8'd0;
  localparam logic [7:0] REG_STAT = 8'd1;
  localparam logic [7:0] REG_CMD  = 8'd2;    // Write pushes into the FIFO

  // Control register bit positions
  localparam int CTRL_EN      = 0;
  localparam int CTRL_IE_DONE = 1;
  localparam int CTRL_IE_OVFL = 2;

  //--------------------------------------------------------------------
  // Status word
  //--------------------------------------------------------------------
  typedef struct packed {
    logic       busy;
    logic       ovfl_flag;                   // Sticky, write one to clear
    logic       done_flag;                   // Sticky, write one to clear
    logic       fifo_full;
    logic       fifo_empty;
    logic [2:0] rsvd;
    logic [3:0] empty_cnt;
    logic [3:0] cnt;
  } gpu_stat_t;

endpackage

// File: source/ogfx_gpu_pkg.sv
package ogfx_gpu_pkg;

  //--------------------------------------------------------------------
  // Command words
  //--------------------------------------------------------------------
  typedef enum logic [1:0] {
    OP_NOP      = 2'd0,
    OP_SET_ADDR = 2'd1,                      // Next word is the address
    OP_FILL     = 2'd2,                      // Next word is the color
    OP_WRITE    = 2'd3                       // One data word per pixel follows
  } gpu_op_e;

  typedef struct packed {
    gpu_op_e     opcode;
    logic [13:0] cnt;                        // Pixel count
  } gpu_hdr_t;

  // Header when it starts a command, raw when it is an operand
  typedef union packed {
    gpu_hdr_t    hdr;
    logic [15:0] raw;
  } gpu_word_u;

  //--------------------------------------------------------------------
  // Video RAM write port
  //--------------------------------------------------------------------
  typedef struct packed {
    logic [15:0] addr;                       // Upper bits above VID_AW are zero
    logic [15:0] data;
  } vram_wr_t;

endpackage

// File: source/ogfx_reg_fifo.sv
`timescale 1ns/1ps

module ogfx_reg_fifo (
  input  logic        mclk,
  input  logic        puc_rst,
  input  logic        fifo_enable_i,
  input  logic        fifo_push_i,
  input  logic        fifo_pop_i,
  input  logic [15:0] fifo_data_i,
  output logic [15:0] fifo_data_o,
  output logic [3:0]  fifo_cnt_o,
  output logic [3:0]  fifo_empty_cnt_o,
  output logic        fifo_empty_o,
  output logic        fifo_full_o,
  output logic        fifo_done_evt_o,
  output logic        fifo_ovfl_evt_o
);

  localparam logic [3:0] FIFO_EMPTY = 4'h0;
  localparam logic [3:0] FIFO_FULL  = 4'hf;
  localparam logic [3:0] PTR_LAST   = 4'he;  // 15 entries, pointers wrap here

  logic [15:0] fifo_mem [0:14];
  logic [3:0]  wr_ptr;
  logic [3:0]  rd_ptr;
  logic [3:0]  cnt_nxt;
  logic        push_int;
  logic        pop_int;

  function automatic logic [3:0] ptr_inc(input logic [3:0] ptr);
    return (ptr == PTR_LAST) ? 4'h0 : ptr + 4'h1;
  endfunction

  assign fifo_full_o      = (fifo_cnt_o == FIFO_FULL);
  assign fifo_empty_o     = (fifo_cnt_o == FIFO_EMPTY);
  assign fifo_empty_cnt_o = FIFO_FULL - fifo_cnt_o;

  assign push_int = fifo_enable_i & fifo_push_i & ~fifo_full_o;
  assign pop_int  = fifo_enable_i & fifo_pop_i & ~fifo_empty_o;

  assign fifo_done_evt_o = ~fifo_empty_o & (cnt_nxt == FIFO_EMPTY);
  assign fifo_ovfl_evt_o = fifo_push_i & fifo_full_o;   // Word is dropped

  //--------------------------------------------------------------------
  // Fill level
  //--------------------------------------------------------------------
  always_comb
  begin
    if (!fifo_enable_i)
      cnt_nxt = FIFO_EMPTY;                 // Disable flushes
    else if (push_int && !pop_int)
      cnt_nxt = fifo_cnt_o + 4'h1;
    else if (pop_int && !push_int)
      cnt_nxt = fifo_cnt_o - 4'h1;
    else
      cnt_nxt = fifo_cnt_o;
  end

  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
    begin
      fifo_cnt_o <= FIFO_EMPTY;
      wr_ptr     <= 4'h0;
      rd_ptr     <= 4'h0;
    end
    else
    begin
      fifo_cnt_o <= cnt_nxt;
      if (!fifo_enable_i)
      begin
        wr_ptr <= 4'h0;
        rd_ptr <= 4'h0;
      end
      else
      begin
        if (push_int)
          wr_ptr <= ptr_inc(wr_ptr);
        if (pop_int)
          rd_ptr <= ptr_inc(rd_ptr);
      end
    end
  end

  //--------------------------------------------------------------------
  // Storage
  //--------------------------------------------------------------------
  always_ff @(posedge mclk)
  begin
    if (push_int)
      fifo_mem[wr_ptr] <= fifo_data_i;
  end

  assign fifo_data_o = fifo_mem[rd_ptr];    // Head word, valid when not empty

  // Fill level matches the words held between the pointers, at most 15
  a_cnt_ptr: assert property (@(posedge mclk) disable iff (puc_rst)
    ((({1'b0, rd_ptr} + {1'b0, fifo_cnt_o}) % 5'd15) == {1'b0, wr_ptr}));

endmodule

// File: source/ogfx_reg.sv
`timescale 1ns/1ps

module ogfx_reg (
  input  logic                   mclk,
  input  logic                   puc_rst,
  input  ogfx_reg_pkg::per_bus_t per_i,
  input  logic [3:0]             fifo_cnt_i,
  input  logic [3:0]             fifo_empty_cnt_i,
  input  logic                   fifo_empty_i,
  input  logic                   fifo_full_i,
  input  logic                   fifo_done_evt_i,
  input  logic                   fifo_ovfl_evt_i,
  input  logic                   fsm_busy_i,
  output logic [15:0]            per_dout_o,
  output logic                   fifo_push_o,
  output logic [15:0]            fifo_din_o,
  output logic                   gpu_en_o,
  output logic                   irq_o
);

  import ogfx_reg_pkg::*;

  logic      sel_ctrl;
  logic      sel_stat;
  logic      sel_cmd;
  logic      rd_en;
  logic [2:0] ctrl;
  logic      done_flag;
  logic      ovfl_flag;
  gpu_stat_t stat_wr;
  gpu_stat_t stat;

  //--------------------------------------------------------------------
  // Register decode
  //--------------------------------------------------------------------
  assign sel_ctrl = per_i.en && (per_i.addr == REG_CTRL);
  assign sel_stat = per_i.en && (per_i.addr == REG_STAT);
  assign sel_cmd  = per_i.en && (per_i.addr == REG_CMD);
  assign rd_en    = per_i.en && !per_i.we;

  assign stat_wr = per_i.din;               // Clear mask in status layout

  assign fifo_push_o = sel_cmd && per_i.we;
  assign fifo_din_o  = per_i.din;

  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
      ctrl <= 3'b000;
    else if (sel_ctrl && per_i.we)
      ctrl <= per_i.din[CTRL_IE_OVFL:CTRL_EN];
  end

  assign gpu_en_o = ctrl[CTRL_EN];

  //--------------------------------------------------------------------
  // Sticky flags
  //--------------------------------------------------------------------
  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
    begin
      done_flag <= 1'b0;
      ovfl_flag <= 1'b0;
    end
    else
    begin
      if (fifo_done_evt_i)
        done_flag <= 1'b1;                  // New event wins over clear
      else if (sel_stat && per_i.we && stat_wr.done_flag)
        done_flag <= 1'b0;
      if (fifo_ovfl_evt_i)
        ovfl_flag <= 1'b1;
      else if (sel_stat && per_i.we && stat_wr.ovfl_flag)
        ovfl_flag <= 1'b0;
    end
  end

  assign irq_o = (done_flag & ctrl[CTRL_IE_DONE]) | (ovfl_flag & ctrl[CTRL_IE_OVFL]);

  //--------------------------------------------------------------------
  // Read path
  //--------------------------------------------------------------------
  always_comb
  begin
    stat            = '0;
    stat.busy       = fsm_busy_i | ~fifo_empty_i;
    stat.ovfl_flag  = ovfl_flag;
    stat.done_flag  = done_flag;
    stat.fifo_full  = fifo_full_i;
    stat.fifo_empty = fifo_empty_i;
    stat.empty_cnt  = fifo_empty_cnt_i;
    stat.cnt        = fifo_cnt_i;
  end

  always_comb
  begin
    per_dout_o = 16'h0000;
    if (rd_en)
    begin
      case (per_i.addr)
        REG_CTRL: per_dout_o = {13'h0000, ctrl};
        REG_STAT: per_dout_o = stat;
        default:  per_dout_o = 16'h0000;  // Command register reads zero
      endcase
    end
  end

  a_one_sel: assert property (@(posedge mclk) disable iff (puc_rst)
    $onehot0({sel_ctrl, sel_stat, sel_cmd}));

endmodule

// File: source/ogfx_gpu_fsm.sv
`timescale 1ns/1ps

module ogfx_gpu_fsm (
  input  logic                    mclk,
  input  logic                    puc_rst,
  input  logic                    gpu_en_i,
  input  logic                    fifo_empty_i,
  input  ogfx_gpu_pkg::gpu_word_u fifo_data_i,
  input  logic                    cnt_zero_i,
  output logic                    fifo_pop_o,
  output logic                    addr_load_o,
  output logic                    cnt_load_o,
  output logic                    color_load_o,
  output logic                    pix_fill_o,
  output logic                    pix_data_o,
  output logic                    busy_o
);

  import ogfx_gpu_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    ADDR,
    COLOR,
    FILL,
    WRITE
  } state_e;

  state_e state;
  state_e state_nxt;

  //--------------------------------------------------------------------
  // Next state and strobes
  //--------------------------------------------------------------------
  always_comb
  begin
    state_nxt    = state;
    fifo_pop_o   = 1'b0;
    addr_load_o  = 1'b0;
    cnt_load_o   = 1'b0;
    color_load_o = 1'b0;
    pix_fill_o   = 1'b0;
    pix_data_o   = 1'b0;
    if (!gpu_en_i)
      state_nxt = IDLE;                     // Disable aborts the command
    else
    begin
      case (state)
        IDLE:
        begin
          if (!fifo_empty_i)
          begin
            fifo_pop_o = 1'b1;              // Header decoded as it pops
            case (fifo_data_i.hdr.opcode)
              OP_SET_ADDR:
                state_nxt = ADDR;
              OP_FILL:
              begin
                cnt_load_o = 1'b1;
                state_nxt  = COLOR;
              end
              OP_WRITE:
              begin
                cnt_load_o = 1'b1;
                state_nxt  = WRITE;
              end
              default:
                state_nxt = IDLE;
            endcase
          end
        end
        ADDR:
        begin
          if (!fifo_empty_i)
          begin
            fifo_pop_o  = 1'b1;
            addr_load_o = 1'b1;
            state_nxt   = IDLE;
          end
        end
        COLOR:
        begin
          if (!fifo_empty_i)
          begin
            fifo_pop_o   = 1'b1;
            color_load_o = 1'b1;
            state_nxt    = FILL;
          end
        end
        FILL:
        begin
          if (cnt_zero_i)
            state_nxt = IDLE;
          else
            pix_fill_o = 1'b1;              // One pixel per cycle
        end
        WRITE:
        begin
          if (cnt_zero_i)
            state_nxt = IDLE;
          else if (!fifo_empty_i)
          begin
            fifo_pop_o = 1'b1;
            pix_data_o = 1'b1;
          end
        end
        default:
          state_nxt = IDLE;
      endcase
    end
  end

  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  assign busy_o = (state != IDLE);

  a_pop_nonempty: assert property (@(posedge mclk) disable iff (puc_rst)
    fifo_pop_o |-> !fifo_empty_i);

endmodule

// File: source/ogfx_gpu_cnt.sv
`timescale 1ns/1ps

module ogfx_gpu_cnt #(
  parameter int VID_AW = 12
) (
  input  logic              mclk,
  input  logic              puc_rst,
  input  logic              gpu_en_i,
  input  logic              cnt_load_i,
  input  logic [13:0]       cnt_i,
  input  logic              addr_load_i,
  input  logic [15:0]       addr_i,
  input  logic              step_i,
  output logic              cnt_zero_o,
  output logic [VID_AW-1:0] cur_addr_o
);

  logic [13:0] cnt;

  // Pixels left in the current command
  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
      cnt <= 14'd0;
    else if (!gpu_en_i)
      cnt <= 14'd0;
    else if (cnt_load_i)
      cnt <= cnt_i;
    else if (step_i)
      cnt <= cnt - 14'd1;
  end

  assign cnt_zero_o = (cnt == 14'd0);

  // Address survives disable and wraps at 2**VID_AW
  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
      cur_addr_o <= '0;
    else if (addr_load_i)
      cur_addr_o <= addr_i[VID_AW-1:0];
    else if (step_i)
      cur_addr_o <= cur_addr_o + 1'b1;
  end

endmodule

// File: source/ogfx_vram_wr.sv
`timescale 1ns/1ps

module ogfx_vram_wr (
  input  logic                    mclk,
  input  logic                    puc_rst,
  input  logic                    color_load_i,
  input  logic                    pix_fill_i,
  input  logic                    pix_data_i,
  input  ogfx_gpu_pkg::gpu_word_u word_i,
  input  logic [15:0]             addr_i,
  output logic                    vram_we_o,
  output ogfx_gpu_pkg::vram_wr_t  vram_o
);

  import ogfx_gpu_pkg::*;

  logic [15:0] color;
  vram_wr_t    wr_nxt;

  always_ff @(posedge mclk)
  begin
    if (color_load_i)
      color <= word_i.raw;
  end

  always_comb
  begin
    wr_nxt.addr = addr_i;
    wr_nxt.data = pix_fill_i ? color : word_i.raw;
  end

  always_ff @(posedge mclk or posedge puc_rst)
  begin
    if (puc_rst)
      vram_we_o <= 1'b0;
    else
      vram_we_o <= pix_fill_i | pix_data_i;
  end

  always_ff @(posedge mclk)
  begin
    if (pix_fill_i || pix_data_i)
      vram_o <= wr_nxt;
  end

  a_one_src: assert property (@(posedge mclk) disable iff (puc_rst)
    !(pix_fill_i && pix_data_i));

endmodule

// File: source/ogfx_gpu.sv
`timescale 1ns/1ps

module ogfx_gpu #(
  parameter int VID_AW = 12
) (
  input  logic                   mclk,
  input  logic                   puc_rst,
  input  ogfx_reg_pkg::per_bus_t per_i,
  output logic [15:0]            per_dout_o,
  output logic                   irq_o,
  output logic                   vram_we_o,
  output ogfx_gpu_pkg::vram_wr_t vram_o
);

  import ogfx_gpu_pkg::*;

  logic              fifo_push;
  logic [15:0]       fifo_din;
  logic              fifo_pop;
  gpu_word_u         fifo_dout;
  logic [3:0]        fifo_cnt;
  logic [3:0]        fifo_empty_cnt;
  logic              fifo_empty;
  logic              fifo_full;
  logic              fifo_done_evt;
  logic              fifo_ovfl_evt;
  logic              gpu_en;
  logic              fsm_busy;
  logic              addr_load;
  logic              cnt_load;
  logic              color_load;
  logic              pix_fill;
  logic              pix_data;
  logic              cnt_zero;
  logic [VID_AW-1:0] cur_addr;

  //--------------------------------------------------------------------
  // Register side
  //--------------------------------------------------------------------
  ogfx_reg reg_i (
    .mclk             (mclk),
    .puc_rst          (puc_rst),
    .per_i            (per_i),
    .fifo_cnt_i       (fifo_cnt),
    .fifo_empty_cnt_i (fifo_empty_cnt),
    .fifo_empty_i     (fifo_empty),
    .fifo_full_i      (fifo_full),
    .fifo_done_evt_i  (fifo_done_evt),
    .fifo_ovfl_evt_i  (fifo_ovfl_evt),
    .fsm_busy_i       (fsm_busy),
    .per_dout_o       (per_dout_o),
    .fifo_push_o      (fifo_push),
    .fifo_din_o       (fifo_din),
    .gpu_en_o         (gpu_en),
    .irq_o            (irq_o)
  );

  ogfx_reg_fifo fifo_i (
    .mclk             (mclk),
    .puc_rst          (puc_rst),
    .fifo_enable_i    (gpu_en),
    .fifo_push_i      (fifo_push),
    .fifo_pop_i       (fifo_pop),
    .fifo_data_i      (fifo_din),
    .fifo_data_o      (fifo_dout),
    .fifo_cnt_o       (fifo_cnt),
    .fifo_empty_cnt_o (fifo_empty_cnt),
    .fifo_empty_o     (fifo_empty),
    .fifo_full_o      (fifo_full),
    .fifo_done_evt_o  (fifo_done_evt),
    .fifo_ovfl_evt_o  (fifo_ovfl_evt)
  );

  //--------------------------------------------------------------------
  // Command engine
  //--------------------------------------------------------------------
  ogfx_gpu_fsm fsm_i (
    .mclk         (mclk),
    .puc_rst      (puc_rst),
    .gpu_en_i     (gpu_en),
    .fifo_empty_i (fifo_empty),
    .fifo_data_i  (fifo_dout),
    .cnt_zero_i   (cnt_zero),
    .fifo_pop_o   (fifo_pop),
    .addr_load_o  (addr_load),
    .cnt_load_o   (cnt_load),
    .color_load_o (color_load),
    .pix_fill_o   (pix_fill),
    .pix_data_o   (pix_data),
    .busy_o       (fsm_busy)
  );

  ogfx_gpu_cnt #(
    .VID_AW (VID_AW)
  ) cnt_i (
    .mclk        (mclk),
    .puc_rst     (puc_rst),
    .gpu_en_i    (gpu_en),
    .cnt_load_i  (cnt_load),
    .cnt_i       (fifo_dout.hdr.cnt),
    .addr_load_i (addr_load),
    .addr_i      (fifo_dout.raw),
    .step_i      (pix_fill | pix_data),  // One step per written pixel
    .cnt_zero_o  (cnt_zero),
    .cur_addr_o  (cur_addr)
  );

  ogfx_vram_wr vram_wr_i (
    .mclk         (mclk),
    .puc_rst      (puc_rst),
    .color_load_i (color_load),
    .pix_fill_i   (pix_fill),
    .pix_data_i   (pix_data),
    .word_i       (fifo_dout),
    .addr_i       (16'(cur_addr)),
    .vram_we_o    (vram_we_o),
    .vram_o       (vram_o)
  );

endmodule

// File: dv/tb_ogfx_gpu.sv
`timescale 1ns/1ps

module tb_ogfx_gpu;

  import ogfx_reg_pkg::*;
  import ogfx_gpu_pkg::*;

  localparam int VID_AW     = 12;
  localparam int MAX_CYCLES = 20000;        // Summed test lengths times two

  typedef logic [15:0] word_q_t [$];

  logic        mclk;
  logic        puc_rst;
  per_bus_t    per;
  logic [15:0] per_dout;
  logic        irq;
  logic        vram_we;
  vram_wr_t    vram;

  vram_wr_t          exp_q [$];             // Writes still owed by the DUT
  logic [VID_AW-1:0] model_addr;
  logic [31:0]       rng_state;
  logic              skip_wr;               // Aborted streams write unknown pixels
  int                err_cnt;
  int                err_mark;
  int                test_num;
  int                pass_cnt;
  int                fail_cnt;
  int                cycle_cnt;

  ogfx_gpu #(
    .VID_AW (VID_AW)
  ) dut_i (
    .mclk       (mclk),
    .puc_rst    (puc_rst),
    .per_i      (per),
    .per_dout_o (per_dout),
    .irq_o      (irq),
    .vram_we_o  (vram_we),
    .vram_o     (vram)
  );

  initial
  begin
    mclk = 1'b0;
    forever #20 mclk = ~mclk;
  end

  //----------------------------------------------------------------------
  // Reference model
  //----------------------------------------------------------------------
  function automatic void expand_cmds(input word_q_t words);
    gpu_word_u   w;
    vram_wr_t    wr;
    logic [15:0] color;
    int          i;
    int          n;
    i = 0;
    while (i < words.size())
    begin
      w = words[i];
      i++;
      case (w.hdr.opcode)
        OP_SET_ADDR:
        begin
          model_addr = words[i][VID_AW-1:0];
          i++;
        end
        OP_FILL:
        begin
          color = words[i];                 // Taken even for a count of zero
          i++;
          for (n = 0; n < w.hdr.cnt; n++)
          begin
            wr.addr = 16'(model_addr);
            wr.data = color;
            exp_q.push_back(wr);
            model_addr++;
          end
        end
        OP_WRITE:
        begin
          for (n = 0; n < w.hdr.cnt; n++)
          begin
            wr.addr = 16'(model_addr);
            wr.data = words[i];
            i++;
            exp_q.push_back(wr);
            model_addr++;
          end
        end
        default:
          ;
      endcase
    end
  endfunction

  function automatic gpu_stat_t expect_stat(input logic busy, input logic ovfl,
                                            input logic done, input logic [3:0] cnt);
    gpu_stat_t s;
    s            = '0;
    s.busy       = busy;
    s.ovfl_flag  = ovfl;
    s.done_flag  = done;
    s.fifo_full  = (cnt == 4'd15);
    s.fifo_empty = (cnt == 4'd0);
    s.empty_cnt  = 4'd15 - cnt;
    s.cnt        = cnt;
    return s;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic logic [15:0] hdr_word(input gpu_op_e op, input logic [13:0] cnt);
    gpu_word_u w;
    w.hdr.opcode = op;
    w.hdr.cnt    = cnt;
    return w.raw;
  endfunction

  function automatic logic [15:0] ctrl_word(input logic en, input logic ie_done,
                                            input logic ie_ovfl);
    logic [15:0] c;
    c               = '0;
    c[CTRL_EN]      = en;
    c[CTRL_IE_DONE] = ie_done;
    c[CTRL_IE_OVFL] = ie_ovfl;
    return c;
  endfunction

  //----------------------------------------------------------------------
  // Compare tasks and write monitor
  //----------------------------------------------------------------------
  task automatic check_write(input vram_wr_t exp, input vram_wr_t act);
    if (act !== exp)
    begin
      $display("FAIL vram_o expected %h got %h", exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_stat(input gpu_stat_t exp, input gpu_stat_t act);
    if (act !== exp)
    begin
      $display("FAIL per_dout_o expected %h got %h", exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_irq(input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAIL irq_o expected %h got %h", exp, act);
      err_cnt++;
    end
  endtask

  always @(negedge mclk)
  begin
    if (!puc_rst && vram_we && !skip_wr)
    begin
      if (exp_q.size() == 0)
      begin
        $display("video RAM write to address %h came with nothing expected", vram.addr);
        err_cnt++;
      end
      else
        check_write(exp_q.pop_front(), vram);
    end
  end

  //----------------------------------------------------------------------
  // Bus cycles
  //----------------------------------------------------------------------
  task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
    @(negedge mclk);
    per.addr = addr;
    per.din  = data;
    per.en   = 1'b1;
    per.we   = 1'b1;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [15:0] data);
    @(negedge mclk);
    per.addr = addr;
    per.din  = '0;
    per.en   = 1'b1;
    per.we   = 1'b0;
    #1;
    data = per_dout;                        // Combinational read data
  endtask

  task automatic idle_cycles(input int n);
    repeat (n)
    begin
      @(negedge mclk);
      per = '0;
    end
  endtask

  task automatic clear_flags();
    gpu_stat_t m;
    m           = '0;
    m.ovfl_flag = 1'b1;
    m.done_flag = 1'b1;
    bus_write(REG_STAT, m);
  endtask

  task automatic push_stream(input word_q_t words);
    foreach (words[i])
      bus_write(REG_CMD, words[i]);
  endtask

  task automatic run_stream(input word_q_t words);
    expand_cmds(words);
    push_stream(words);
    idle_cycles(1);
  endtask

  task automatic wait_idle();
    gpu_stat_t   st;
    logic [15:0] rd;
    st      = '0;
    st.busy = 1'b1;
    while (st.busy)
    begin
      bus_read(REG_STAT, rd);
      st = rd;
    end
    idle_cycles(1);
  endtask

  task automatic begin_test();
    test_num++;
    err_mark = err_cnt;
  endtask

  task automatic end_test(input string name);
    if (exp_q.size() != 0)
    begin
      $display("%0d expected video RAM writes never appeared", exp_q.size());
      err_cnt++;
      exp_q.delete();
    end
    if (err_cnt == err_mark)
    begin
      pass_cnt++;
      $display("test %0d %s ok", test_num, name);
    end
    else
    begin
      fail_cnt++;
      $display("test %0d %s failed", test_num, name);
    end
  endtask

  //----------------------------------------------------------------------
  // Tests
  //----------------------------------------------------------------------
  task automatic test_reset();
    logic [15:0] rd;
    begin_test();
    bus_read(REG_STAT, rd);
    check_stat(expect_stat(1'b0, 1'b0, 1'b0, 4'd0), rd);
    check_irq(1'b0, irq);
    bus_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
    idle_cycles(1);
    end_test("reset state");
  endtask

  task automatic test_write();
    word_q_t     words;
    logic [15:0] rd;
    int          n;
    begin_test();
    bus_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
    clear_flags();
    n = 1 + next_rand() % 12;
    words.push_back(hdr_word(OP_SET_ADDR, 14'd0));
    words.push_back(16'(next_rand()));
    words.push_back(hdr_word(OP_WRITE, 14'(n)));
    repeat (n)
      words.push_back(16'(next_rand()));
    run_stream(words);
    wait_idle();
    bus_read(REG_STAT, rd);
    check_stat(expect_stat(1'b0, 1'b0, 1'b1, 4'd0), rd);
    idle_cycles(1);
    end_test("set_addr then write");
  endtask

  task automatic test_fill();
    word_q_t     words;
    logic [15:0] rd;
    begin_test();
    bus_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
    clear_flags();
    words.push_back(hdr_word(OP_SET_ADDR, 14'd0));
    words.push_back(16'(next_rand()));
    words.push_back(hdr_word(OP_FILL, 14'(1 + next_rand() % 24)));
    words.push_back(16'(next_rand()));
    words.push_back(hdr_word(OP_SET_ADDR, 14'd0));
    words.push_back(16'(12'hffc + next_rand() % 4));   // Wraps past 4095
    words.push_back(hdr_word(OP_FILL, 14'(8 + next_rand() % 8)));
    words.push_back(16'(next_rand()));
    words.push_back(hdr_word(OP_FILL, 14'd0));
    words.push_back(16'(next_rand()));
    words.push_back(hdr_word(OP_WRITE, 14'd2));         // Address must be untouched
    words.push_back(16'(next_rand()));
    words.push_back(16'(next_rand()));
    run_stream(words);
    wait_idle();
    bus_read(REG_STAT, rd);
    check_stat(expect_stat(1'b0, 1'b0, 1'b1, 4'd0), rd);
    idle_cycles(1);
    end_test("fill");
  endtask

  task automatic test_overflow();
    word_q_t     words;
    word_q_t     taken;
    logic [15:0] rd;
    begin_test();
    bus_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b1));
    clear_flags();
    words.push_back(hdr_word(OP_FILL, 14'd200));
    words.push_back(16'(next_rand()));
    words.push_back(hdr_word(OP_WRITE, 14'd14));
    repeat (19)
      words.push_back(16'(next_rand()));
    // Last five pushes meet a full FIFO
    for (int i = 0; i < 17; i++)
      taken.push_back(words[i]);
    expand_cmds(taken);
    push_stream(words);
    bus_read(REG_STAT, rd);
    check_stat(expect_stat(1'b1, 1'b1, 1'b0, 4'd15), rd);
    check_irq(1'b1, irq);
    wait_idle();
    bus_read(REG_STAT, rd);
    check_stat(expect_stat(1'b0, 1'b1, 1'b1, 4'd0), rd);
    idle_cycles(1);
    end_test("overflow");
  endtask

  task automatic test_irq();
    word_q_t     words;
    logic [15:0] rd;
    int          n;
    begin_test();
    check_irq(1'b1, irq);
    clear_flags();
    bus_read(REG_STAT, rd);
    check_stat(expect_stat(1'b0, 1'b0, 1'b0, 4'd0), rd);
    check_irq(1'b0, irq);
    bus_write(REG_CTRL, ctrl_word(1'b1, 1'b1, 1'b0));
    n = 1 + next_rand() % 6;
    words.push_back(hdr_word(OP_SET_ADDR, 14'd0));
    words.push_back(16'(next_rand()));
    words.push_back(hdr_word(OP_WRITE, 14'(n)));
    repeat (n)
      words.push_back(16'(next_rand()));
    run_stream(words);
    wait_idle();
    bus_read(REG_STAT, rd);
    check_stat(expect_stat(1'b0, 1'b0, 1'b1, 4'd0), rd);
    check_irq(1'b1, irq);
    idle_cycles(1);
    end_test("flag clear and interrupt");
  endtask

  task automatic test_disable();
    word_q_t     words;
    word_q_t     fresh;
    logic [15:0] rd;
    int          n;
    begin_test();
    bus_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
    clear_flags();
    skip_wr = 1'b1;
    words.push_back(hdr_word(OP_SET_ADDR, 14'd0));
    words.push_back(16'(next_rand()));
    words.push_back(hdr_word(OP_FILL, 14'd300));
    words.push_back(16'(next_rand()));
    words.push_back(hdr_word(OP_WRITE, 14'd3));
    repeat (3)
      words.push_back(16'(next_rand()));
    push_stream(words);
    idle_cycles(10);
    bus_write(REG_CTRL, 16'h0000);          // Abort with words still queued
    idle_cycles(2);
    bus_read(REG_STAT, rd);
    check_stat(expect_stat(1'b0, 1'b0, 1'b1, 4'd0), rd);
    check_irq(1'b0, irq);
    skip_wr = 1'b0;
    bus_write(REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
    n = 1 + next_rand() % 12;
    fresh.push_back(hdr_word(OP_SET_ADDR, 14'd0));
    fresh.push_back(16'(next_rand()));
    fresh.push_back(hdr_word(OP_WRITE, 14'(n)));
    repeat (n)
      fresh.push_back(16'(next_rand()));
    run_stream(fresh);
    wait_idle();
    bus_read(REG_STAT, rd);
    check_stat(expect_stat(1'b0, 1'b0, 1'b1, 4'd0), rd);
    idle_cycles(1);
    end_test("disable");
  endtask

  //----------------------------------------------------------------------
  // Run control
  //----------------------------------------------------------------------
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES)
    begin
      @(posedge mclk);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles without finishing", cycle_cnt);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    per        = '0;
    puc_rst    = 1'b1;
    rng_state  = 32'h1134e7f0;
    model_addr = '0;
    skip_wr    = 1'b0;
    err_cnt    = 0;
    err_mark   = 0;
    test_num   = 0;
    pass_cnt   = 0;
    fail_cnt   = 0;
    repeat (3) @(negedge mclk);
    puc_rst = 1'b0;
    test_reset();
    test_write();
    test_fill();
    test_overflow();
    test_irq();
    test_disable();
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (err_cnt == 0 && fail_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: all.f
source/ogfx_reg_pkg.sv
source/ogfx_gpu_pkg.sv
source/ogfx_reg_fifo.sv
source/ogfx_reg.sv
source/ogfx_gpu_fsm.sv
source/ogfx_gpu_cnt.sv
source/ogfx_vram_wr.sv
source/ogfx_gpu.sv
dv/tb_ogfx_gpu.sv
